/* hdl/liftPkg.sv */
package liftPkg;

	localparam int MaxFloors = 8;  // widest building the types can hold
	localparam int DoorCntW = 4;   // dwell counter width, DwellCycles must fit

	typedef logic [2:0] floorIdx_t;  // floor number 0..MaxFloors-1
	typedef logic [3:0] carPos_t;    // half-floors, even = at a floor, odd = between

	// travel state, same encoding the old controller used
	typedef enum logic [1:0] {
		dirIdle = 2'b00,
		dirUp   = 2'b01,
		dirDown = 2'b10
	} dir_t;

	// one bit per floor for each kind of call
	typedef struct packed {
		logic [MaxFloors-1:0] carCall;   // buttons inside the car
		logic [MaxFloors-1:0] hallUp;    // up buttons on the landings
		logic [MaxFloors-1:0] hallDown;  // down buttons on the landings
	} callSet_t;

	typedef struct packed {
		logic openBtn;   // door open button in the car
		logic closeBtn;  // door close button in the car
		logic sensor;    // doorway obstruction sensor
	} doorBtn_t;

	// status seen from outside, also what the scheduler works from
	typedef struct packed {
		carPos_t pos;
		dir_t dir;
		logic doorOpen;
	} carStatus_t;

endpackage

/* hdl/callRegister.sv */
`timescale 1ns/10ps

module callRegister import liftPkg::*; #(
	parameter int NumFloors = 4
) (
	input logic clk,
	input logic reset,
	input callSet_t calls,
	input floorIdx_t serveFloor,
	input logic serveStrobe,
	input logic clearAll,
	output callSet_t pending
);

	logic [MaxFloors-1:0] floorMask;  // floors that exist in this building
	logic [MaxFloors-1:0] keepMask;   // all ones except the floor being served

	always_comb begin
		floorMask = '0;
		keepMask = '1;
		for (int i = 0; i < MaxFloors; i++) begin
			floorMask[i] = (i < NumFloors);  // upper bits never latch
		end
		if (serveStrobe) begin
			keepMask[serveFloor] = 1'b0;  // drop car and both hall calls here
		end
	end

	// a held button re-latches after the serve clears it
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else if (clearAll) begin
			pending <= '0;  // emergency wipes every call
		end else begin
			pending.carCall <= ((pending.carCall & keepMask) | calls.carCall) & floorMask;
			pending.hallUp <= ((pending.hallUp & keepMask) | calls.hallUp) & floorMask;
			pending.hallDown <= ((pending.hallDown & keepMask) | calls.hallDown) & floorMask;
		end
	end

	// scheduler only serves floors that exist
	assert property (@(posedge clk) disable iff (reset)
		serveStrobe |-> (int'(serveFloor) < NumFloors))
	else
		$error("ERR callRegister serveFloor=%h out of range", serveFloor);

endmodule

/* hdl/travelScheduler.sv */
`timescale 1ns/10ps

module travelScheduler import liftPkg::*; #(
	parameter int NumFloors = 4
) (
	input logic clk,
	input logic reset,
	input callSet_t pending,
	input carPos_t pos,
	input logic doorOpen,
	input logic emergency,
	input logic openBtn,
	output dir_t dir,
	output logic step,
	output dir_t stepDir,
	output logic openReq,
	output floorIdx_t serveFloor,
	output logic serveStrobe,
	output logic clearAll
);

	floorIdx_t curFloor;             // floor at or just below the car
	logic atFloor;                   // even half-floor position
	logic [MaxFloors-1:0] anyCall;   // any kind of call per floor
	logic callAbove;
	logic callBelow;
	logic carHere;
	logic upHere;
	logic downHere;
	logic anyHere;
	logic ahead;         // calls remain in the travel direction
	logic dirMatchHere;  // hall call here that matches the travel direction
	logic serveHere;
	dir_t nextDir;       // direction chosen at this floor
	dir_t dirNext;       // register input

	assign curFloor = floorIdx_t'(pos[3:1]);
	assign atFloor = ~pos[0];
	assign anyCall = pending.carCall | pending.hallUp | pending.hallDown;
	assign carHere = pending.carCall[curFloor];
	assign upHere = pending.hallUp[curFloor];
	assign downHere = pending.hallDown[curFloor];
	assign anyHere = anyCall[curFloor];
	assign serveFloor = curFloor;  // only sampled with serveStrobe

	always_comb begin
		callAbove = 1'b0;
		callBelow = 1'b0;
		for (int i = 0; i < NumFloors; i++) begin
			if (i > int'(curFloor)) callAbove |= anyCall[i];
			if (i < int'(curFloor)) callBelow |= anyCall[i];
		end
	end

	// collective rule: keep going while calls lie ahead, reverse only when none remain
	always_comb begin
		case (dir)
			dirUp: begin
				ahead = callAbove;
				dirMatchHere = upHere;
				nextDir = callAbove ? dirUp : (callBelow ? dirDown : dirIdle);
			end
			dirDown: begin
				ahead = callBelow;
				dirMatchHere = downHere;
				nextDir = callBelow ? dirDown : (callAbove ? dirUp : dirIdle);
			end
			default: begin
				ahead = 1'b0;  // idle car takes any call at its floor
				dirMatchHere = 1'b0;
				nextDir = callAbove ? dirUp : (callBelow ? dirDown : dirIdle);
			end
		endcase
	end

	// stop for car calls, hall calls our way, or anything here once nothing is ahead
	assign serveHere = carHere | dirMatchHere | (anyHere & ~ahead);

	always_comb begin
		step = 1'b0;
		stepDir = dir;
		openReq = 1'b0;
		serveStrobe = 1'b0;
		clearAll = 1'b0;
		dirNext = dir;
		if (!atFloor) begin
			step = 1'b1;  // between floors always finish the move, emergency too
		end else if (emergency) begin
			clearAll = 1'b1;  // park with the door open and forget all calls
			openReq = 1'b1;   // held high so the dwell keeps restarting
			dirNext = dirIdle;
		end else if (!doorOpen) begin
			dirNext = nextDir;
			if (serveHere) begin
				openReq = 1'b1;
				serveStrobe = 1'b1;
			end else if (nextDir != dirIdle) begin
				step = 1'b1;
				stepDir = nextDir;
			end else if (openBtn) begin
				openReq = 1'b1;  // idle car, passenger wants the door
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dir <= dirIdle;
		end else begin
			dir <= dirNext;
		end
	end

	// door only opens at a floor, so the car is never stepped with it open
	assert property (@(posedge clk) disable iff (reset) step |-> !doorOpen)
	else
		$error("ERR travelScheduler step=%h doorOpen=%h", step, doorOpen);

	assert property (@(posedge clk) disable iff (reset) pos[0] |=> dir == $past(dir))
	else
		$error("ERR travelScheduler dir=%h changed at pos=%h", dir, $past(pos));

endmodule

/* hdl/carPosition.sv */
`timescale 1ns/10ps

module carPosition import liftPkg::*; #(
	parameter int NumFloors = 4
) (
	input logic clk,
	input logic reset,
	input logic step,
	input dir_t stepDir,
	output carPos_t pos
);

	localparam carPos_t TopPos = carPos_t'(2 * (NumFloors - 1));  // top floor in half-floors

	logic atTop;
	logic atBottom;

	assign atTop = (pos >= TopPos);
	assign atBottom = (pos == '0);

	// one half-floor per step, clamped at the shaft ends
	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= '0;  // car starts at the ground floor
		end else if (step) begin
			if (stepDir == dirUp && !atTop) begin
				pos <= carPos_t'(pos + 1'b1);
			end else if (stepDir == dirDown && !atBottom) begin
				pos <= carPos_t'(pos - 1'b1);
			end
		end
	end

	// the scheduler has to stop before the shaft ends
	assert property (@(posedge clk) disable iff (reset)
		step && stepDir == dirUp |-> !atTop)
	else
		$error("ERR carPosition step up at pos=%h", pos);

	assert property (@(posedge clk) disable iff (reset)
		step && stepDir == dirDown |-> !atBottom)
	else
		$error("ERR carPosition step down at pos=%h", pos);

	// a step always has a direction
	assert property (@(posedge clk) disable iff (reset)
		step |-> stepDir != dirIdle)
	else
		$error("ERR carPosition stepDir=%h with step", stepDir);

endmodule

/* hdl/doorTimer.sv */
`timescale 1ns/10ps

module doorTimer import liftPkg::*; #(
	parameter int DwellCycles = 5,
	parameter int CloseEarlyAt = 3
) (
	input logic clk,
	input logic reset,
	input logic openReq,
	input doorBtn_t doorBtns,
	output logic doorOpen
);

	localparam logic [DoorCntW-1:0] LastCnt = DoorCntW'(DwellCycles - 1);  // last open clock
	localparam logic [DoorCntW-1:0] EarlyCnt = DoorCntW'(CloseEarlyAt);

	logic [DoorCntW-1:0] cnt;  // clocks the door has been open
	logic dwellDone;
	logic closeEarly;

	assign dwellDone = (cnt >= LastCnt);
	assign closeEarly = doorBtns.closeBtn && (cnt >= EarlyCnt);

	always_ff @(posedge clk) begin
		if (reset) begin
			doorOpen <= 1'b0;
			cnt <= '0;
		end else if (!doorOpen) begin
			if (openReq) begin
				doorOpen <= 1'b1;
				cnt <= '0;
			end
		end else if (openReq || doorBtns.openBtn) begin
			cnt <= '0;  // reopen starts the dwell over
		end else if (closeEarly) begin
			doorOpen <= 1'b0;
		end else if (dwellDone) begin
			if (!doorBtns.sensor) begin
				doorOpen <= 1'b0;
			end  // blocked doorway holds the door open
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// close button alone cannot cut the dwell short before CloseEarlyAt
	assert property (@(posedge clk) disable iff (reset)
		doorOpen && cnt < EarlyCnt && !dwellDone |=> doorOpen)
	else
		$error("ERR doorTimer doorOpen fell at cnt=%h", $past(cnt));

endmodule

/* hdl/liftController.sv */
`timescale 1ns/10ps

module liftController import liftPkg::*; #(
	parameter int NumFloors = 4,
	parameter int DwellCycles = 5,
	parameter int CloseEarlyAt = 3
) (
	input logic clk,
	input logic reset,
	input callSet_t calls,
	input doorBtn_t doorBtns,
	input logic emergency,
	output carStatus_t status
);

	callSet_t pending;     // latched calls
	floorIdx_t serveFloor;
	logic serveStrobe;
	logic clearAll;        // emergency flush
	logic step;
	dir_t stepDir;
	dir_t dir;
	carPos_t pos;
	logic openReq;
	logic doorOpen;

	callRegister #(
		.NumFloors(NumFloors)
	) i_callRegister (
		.clk(clk),
		.reset(reset),
		.calls(calls),
		.serveFloor(serveFloor),
		.serveStrobe(serveStrobe),
		.clearAll(clearAll),
		.pending(pending)
	);

	travelScheduler #(
		.NumFloors(NumFloors)
	) i_travelScheduler (
		.clk(clk),
		.reset(reset),
		.pending(pending),
		.pos(pos),
		.doorOpen(doorOpen),
		.emergency(emergency),
		.openBtn(doorBtns.openBtn),  // idle car opens on request
		.dir(dir),
		.step(step),
		.stepDir(stepDir),
		.openReq(openReq),
		.serveFloor(serveFloor),
		.serveStrobe(serveStrobe),
		.clearAll(clearAll)
	);

	carPosition #(
		.NumFloors(NumFloors)
	) i_carPosition (
		.clk(clk),
		.reset(reset),
		.step(step),
		.stepDir(stepDir),
		.pos(pos)
	);

	doorTimer #(
		.DwellCycles(DwellCycles),
		.CloseEarlyAt(CloseEarlyAt)
	) i_doorTimer (
		.clk(clk),
		.reset(reset),
		.openReq(openReq),
		.doorBtns(doorBtns),
		.doorOpen(doorOpen)
	);

	assign status = '{pos: pos, dir: dir, doorOpen: doorOpen};

endmodule

/* tb/liftChecks.sv */
`timescale 1ns/10ps

module liftChecks import liftPkg::*; #(
	parameter int NumFloors = 4,
	parameter int DwellCycles = 5,
	parameter int CloseEarlyAt = 3
) (
	input logic clk,
	input logic reset,
	input callSet_t calls,
	input doorBtn_t doorBtns,
	input logic emergency,
	input carStatus_t status,
	output logic allServed,
	output logic failed
);

	localparam carPos_t TopPos = carPos_t'(2 * (NumFloors - 1));  // top floor in half-floors

	callSet_t model;               // calls the car still owes
	callSet_t lastCalls;           // buttons one clock back
	logic lastOpen;
	logic lastEmerg;
	int openCnt;                   // clocks since the door opened or reopened
	logic [MaxFloors-1:0] owed;    // any call per floor
	logic [MaxFloors-1:0] above;   // owed floors above the car
	logic [MaxFloors-1:0] below;
	logic [MaxFloors-1:0] served;  // floor the car stands at
	logic closing;                 // close press late enough to count
	logic keepOpen;                // door must still be open next clock

	initial failed = 1'b0;

	assign allServed = (model == '0);
	assign owed = model.carCall | model.hallUp | model.hallDown;
	assign served = MaxFloors'(1) << status.pos[3:1];
	assign closing = doorBtns.closeBtn && openCnt >= CloseEarlyAt;
	assign keepOpen = emergency || doorBtns.openBtn
		|| (!closing && (openCnt < DwellCycles - 1 || doorBtns.sensor));

	always_comb begin
		for (int f = 0; f < MaxFloors; f++) begin
			above[f] = owed[f] && (2 * f > int'(status.pos));
			below[f] = owed[f] && (2 * f < int'(status.pos));
		end
	end

	task automatic reportError(input string msg);
		$display("%s", msg);
		failed = 1'b1;
	endtask

	// own copy of the call register, built from the button presses
	always @(posedge clk) begin
		if (reset) begin
			model <= '0;
			lastCalls <= '0;
			lastOpen <= 1'b0;
			lastEmerg <= 1'b0;
			openCnt <= 0;
		end else begin
			lastCalls <= calls;
			lastOpen <= status.doorOpen;
			lastEmerg <= emergency;
			openCnt <= (!status.doorOpen || doorBtns.openBtn || emergency) ? 0 : openCnt + 1;
			if (emergency && !status.pos[0]) begin
				model <= '0;  // parked in emergency, every call dropped
			end else if (status.doorOpen && !lastOpen && !lastEmerg) begin
				assert (owed[status.pos[3:1]])
				else reportError($sformatf("ERR owed=%h at pos=%h", owed, status.pos));
				// presses during the serve clock survive the clear
				model <= (model & ~{3{served}}) | lastCalls | calls;
			end else begin
				model <= model | calls;
			end
		end
	end

	assert property (@(posedge clk) $past(reset) && !reset
		|-> status.pos == '0 && status.dir == dirIdle && !status.doorOpen)
	else reportError($sformatf("ERR status=%h after reset", status));

	// in the shaft, door shut between floors
	assert property (@(posedge clk) disable iff (reset)
		status.pos <= TopPos && !(status.doorOpen && status.pos[0]))
	else reportError($sformatf("ERR status.pos=%h doorOpen=%h", status.pos, status.doorOpen));

	// one half-floor per clock, matching dir
	assert property (@(posedge clk) disable iff (reset)
		status.pos != $past(status.pos) |->
			(status.pos == carPos_t'($past(status.pos) + 1) && status.dir == dirUp)
			|| (status.pos == carPos_t'($past(status.pos) - 1) && status.dir == dirDown))
	else reportError($sformatf("ERR status.pos=%h dir=%h", status.pos, status.dir));

	assert property (@(posedge clk) disable iff (reset)
		status.doorOpen || $past(status.doorOpen) |-> status.pos == $past(status.pos))
	else reportError($sformatf("ERR status.pos=%h moved with door open", status.pos));

	// collective order, no reversal while calls remain ahead
	assert property (@(posedge clk) disable iff (reset)
		(status.dir == dirUp && |above) || (status.dir == dirDown && |below)
		|=> status.dir == $past(status.dir) || $past(emergency))
	else reportError($sformatf("ERR status.dir=%h owed=%h", status.dir, owed));

	// dwell, close early, sensor hold, reopen
	assert property (@(posedge clk) disable iff (reset)
		status.doorOpen |=> status.doorOpen == $past(keepOpen))
	else reportError($sformatf("ERR status.doorOpen=%h openCnt=%h", status.doorOpen, openCnt));

	assert property (@(posedge clk) disable iff (reset)
		emergency && !status.pos[0] |=> status.doorOpen && status.dir == dirIdle)
	else reportError($sformatf("ERR status=%h in emergency", status));

	assert property (@(posedge clk) disable iff (reset)
		emergency && status.pos[0] |=> !status.pos[0])
	else reportError($sformatf("ERR status.pos=%h not at next floor", status.pos));

endmodule

/* tb/liftTb.sv */
`timescale 1ns/10ps

module liftTb import liftPkg::*; #(
	parameter int Seed = 43
);

	localparam int NumFloors = 4;
	localparam int DwellCycles = 5;
	localparam int CloseEarlyAt = 3;
	localparam int RandCalls = 40;
	// full sweep up and down, stopping for every kind of call on every floor
	localparam int WorstTrip = 4 * (NumFloors - 1) + 3 * NumFloors * (DwellCycles + 2);
	localparam int WatchdogCycles = (RandCalls + 6) * (WorstTrip + 16) + 200;

	logic clk;
	logic reset;
	callSet_t calls;
	doorBtn_t doorBtns;
	logic emergency;
	carStatus_t status;
	logic allServed;        // checker model empty
	logic failed;
	int unsigned lcgState = Seed;

	liftController #(
		.NumFloors(NumFloors),
		.DwellCycles(DwellCycles),
		.CloseEarlyAt(CloseEarlyAt)
	) i_liftController (.*);

	liftChecks #(
		.NumFloors(NumFloors),
		.DwellCycles(DwellCycles),
		.CloseEarlyAt(CloseEarlyAt)
	) i_liftChecks (.*);

	function automatic int unsigned nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;  // low bits of an LCG repeat too soon
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge clk);
		#1;  // drive just after the edge
	endtask

	task automatic press(input int kind, input int floor);
		case (kind)
			0: calls.carCall[floor] = 1'b1;
			1: calls.hallUp[floor] = 1'b1;
			default: calls.hallDown[floor] = 1'b1;
		endcase
		tick(1);  // one clock is enough to latch
		calls = '0;
	endtask

	task automatic untilDoorOpens();
		while (!status.doorOpen) tick(1);
	endtask

	task automatic drainCalls();
		while (!allServed || status.doorOpen || status.dir != dirIdle) tick(1);
	endtask

	task automatic abortRun(input string why);
		$display("Result: FAILED");
		$fatal(1, "%s", why);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		abortRun("watchdog expired before the scenarios finished");
	end

	always @(posedge failed) abortRun("checker found a mismatch");

	initial begin
		reset = 1'b1;
		calls = '0;
		doorBtns = '0;
		emergency = 1'b0;
		tick(16);
		reset = 1'b0;
		tick(2);
		repeat (RandCalls) begin  // random collective traffic
			press(nextRand() % 3, nextRand() % NumFloors);
			tick(1 + nextRand() % 12);
		end
		drainCalls();
		press(0, NumFloors - 1);
		untilDoorOpens();
		tick(1);
		doorBtns.closeBtn = 1'b1;  // too early at first, then counts
		tick(CloseEarlyAt);
		doorBtns.closeBtn = 1'b0;
		drainCalls();
		press(0, 0);
		untilDoorOpens();
		doorBtns.sensor = 1'b1;  // blocked doorway past the dwell
		tick(DwellCycles + 3);
		doorBtns.sensor = 1'b0;
		drainCalls();
		press(1, 1);
		untilDoorOpens();
		tick(2);
		doorBtns.openBtn = 1'b1;  // reopen while open
		tick(1);
		doorBtns.openBtn = 1'b0;
		drainCalls();
		emergency = 1'b1;  // parked at floor 1
		tick(2);
		press(0, NumFloors - 1);
		tick(4);
		emergency = 1'b0;
		drainCalls();
		press(0, NumFloors - 1);
		while (!status.pos[0]) tick(1);
		emergency = 1'b1;  // caught between floors
		untilDoorOpens();
		tick(3);
		emergency = 1'b0;
		drainCalls();
		if (failed) begin
			abortRun("checker found a mismatch");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* liftController.f */
hdl/liftPkg.sv
hdl/callRegister.sv
hdl/travelScheduler.sv
hdl/carPosition.sv
hdl/doorTimer.sv
hdl/liftController.sv
tb/liftChecks.sv
tb/liftTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= liftTb
FILELIST ?= liftController.f
LOG ?= sim.log
SEED ?= 43
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSeed=$(SEED) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o $(TOP)
	-./$(OBJDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
